// ==== Makefile ====
# Verilator build and run of the Hough line finder testbench

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the Verilator build directory"
	@echo "  help   show this list"

test:
	verilator --binary --timing -f hough_lines.f --top-module hough_tb \
		-Mdir obj_dir -o hough_sim
	./obj_dir/hough_sim

clean:
	rm -rf obj_dir

// ==== hdl/hough_accumulator.sv ====
`timescale 1ns/1ns
/*
 * Sequential Hough voter. Votes each popped point over all theta steps and, on
 * the end-of-frame marker, scans and clears the vote memory to report the best line.
 */
`include "hough_config.svh"

module hough_accumulator (
    input  logic                   clock,
    input  logic                   reset,
    output logic                   pop,
    input  hough_pkg::edge_entry_t pop_data,
    input  logic                   fifo_empty,
    output logic                   line_valid,
    output hough_pkg::rho_t        line_rho,
    output hough_pkg::theta_t      line_theta,
    output hough_pkg::vote_t       line_votes
);
    import hough_pkg::*;

    localparam int CELLS     = `THETA_STEPS * `RHO_RANGE;
    localparam int ADDR_BITS = $clog2(CELLS);
    localparam int IDX_BITS  = $clog2(`RHO_RANGE);

    typedef enum logic [2:0] {
        S_CLEAR,
        S_IDLE,
        S_VOTE,
        S_SCAN,
        S_REPORT
    } state_t;

    state_t               state;
    vote_t                votes [CELLS];
    vote_t                rd_data;
    vote_t                wr_data;
    vote_t                vote_inc;
    logic                 wr_en;
    logic [ADDR_BITS-1:0] rd_addr;
    logic [ADDR_BITS-1:0] wr_addr;
    logic [ADDR_BITS-1:0] vote_addr;
    logic [ADDR_BITS-1:0] cnt_addr;
    logic [ADDR_BITS-1:0] v_addr;
    logic                 v_valid;

    // Point being voted
    coord_t               pt_x;
    coord_t               pt_y;
    theta_t               vote_theta;
    logic signed [17:0]   rho_sum;
    rho_t                 vote_rho;
    logic [IDX_BITS-1:0]  vote_idx;

    // Cell walker shared by the clear pass and the scan
    theta_t               cnt_theta;
    logic [IDX_BITS-1:0]  cnt_rho;
    logic                 last_cell;
    logic                 cmp_valid;
    theta_t               cmp_theta;
    logic [IDX_BITS-1:0]  cmp_rho;

    vote_t                best_votes;
    theta_t               best_theta;
    logic [IDX_BITS-1:0]  best_rho;

    // Theta-major layout, so ascending addresses scan theta then rho
    function automatic logic [ADDR_BITS-1:0] cell_addr(theta_t theta,
                                                       logic [IDX_BITS-1:0] idx);
        return ADDR_BITS'(theta * `RHO_RANGE + idx);
    endfunction

    always_comb begin
        rho_sum   = $signed({1'b0, pt_x}) * COS_Q[vote_theta]
                  + $signed({1'b0, pt_y}) * SIN_Q[vote_theta];
        // Arithmetic shift floors negative rho
        vote_rho  = rho_t'(rho_sum >>> 8);
        vote_idx  = IDX_BITS'(vote_rho + `RHO_OFFSET);
        vote_addr = cell_addr(vote_theta, vote_idx);
        cnt_addr  = cell_addr(cnt_theta, cnt_rho);
        last_cell = (cnt_theta == theta_t'(`THETA_STEPS - 1))
                 && (cnt_rho == IDX_BITS'(`RHO_RANGE - 1));
        vote_inc  = (rd_data == 8'hFF) ? rd_data : rd_data + 8'd1;
    end

    // Vote writes land one cycle after their read; clear and scan write zeros
    assign rd_addr = (state == S_VOTE) ? vote_addr : cnt_addr;
    assign wr_en   = v_valid || (state == S_CLEAR) || (state == S_SCAN);
    assign wr_addr = v_valid ? v_addr : cnt_addr;
    assign wr_data = v_valid ? vote_inc : '0;

    assign pop = (state == S_IDLE) && !fifo_empty;

    assign line_rho   = rho_t'($signed({1'b0, best_rho}) - `RHO_OFFSET);
    assign line_theta = best_theta;
    assign line_votes = best_votes;

    // Read returns the old value when the same cell is zeroed
    always_ff @(posedge clock) begin
        if (wr_en) begin
            votes[wr_addr] <= wr_data;
        end
        rd_data <= votes[rd_addr];
    end

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            state      <= S_CLEAR;
            vote_theta <= '0;
            cnt_theta  <= '0;
            cnt_rho    <= '0;
            v_valid    <= 1'b0;
            cmp_valid  <= 1'b0;
            line_valid <= 1'b0;
        end else begin
            v_valid    <= (state == S_VOTE);
            cmp_valid  <= (state == S_SCAN);
            line_valid <= (state == S_REPORT);
            case (state)
                S_CLEAR, S_SCAN: begin
                    if (cnt_rho == IDX_BITS'(`RHO_RANGE - 1)) begin
                        cnt_rho   <= '0;
                        cnt_theta <= last_cell ? '0 : cnt_theta + 1'b1;
                    end else begin
                        cnt_rho <= cnt_rho + 1'b1;
                    end
                    if (last_cell) begin
                        state <= (state == S_CLEAR) ? S_IDLE : S_REPORT;
                    end
                end
                S_IDLE: begin
                    if (pop) begin
                        state <= pop_data.last ? S_SCAN : S_VOTE;
                    end
                end
                S_VOTE: begin
                    if (vote_theta == theta_t'(`THETA_STEPS - 1)) begin
                        vote_theta <= '0;
                        state      <= S_IDLE;
                    end else begin
                        vote_theta <= vote_theta + 1'b1;
                    end
                end
                S_REPORT: begin
                    state <= S_IDLE;
                end
                default: begin
                    state <= S_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clock) begin
        v_addr    <= vote_addr;
        cmp_theta <= cnt_theta;
        cmp_rho   <= cnt_rho;
        if (pop) begin
            pt_x <= pop_data.x;
            pt_y <= pop_data.y;
        end
        // Strict compare keeps the first maximum
        if (pop && pop_data.last) begin
            best_votes <= '0;
            best_theta <= '0;
            best_rho   <= '0;
        end else if (cmp_valid && (rd_data > best_votes)) begin
            best_votes <= rd_data;
            best_theta <= cmp_theta;
            best_rho   <= cmp_rho;
        end
    end

endmodule

// ==== hdl/hough_pkg.sv ====
/*
 * Shared types and quantized trig tables for the Hough line pipeline.
 * Imported by the RTL modules and by the testbench.
 */
`include "hough_config.svh"

package hough_pkg;

    typedef struct packed {
        logic [7:0] red;
        logic [7:0] green;
        logic [7:0] blue;
    } pixel_rgb_t;

    // Same 24-bit word seen as a bus value or as separate channels
    typedef union packed {
        logic [23:0] raw;
        pixel_rgb_t  rgb;
    } pixel_word_t;

    // Coordinates are relative to the window corner
    typedef logic [5:0] coord_t;

    typedef logic signed [7:0] rho_t;
    typedef logic [3:0] theta_t;

    // Saturates at 255
    typedef logic [7:0] vote_t;

    // Entry with last set marks the end of a frame and carries no point
    typedef struct packed {
        logic   last;
        coord_t x;
        coord_t y;
    } edge_entry_t;

    // round(256*cos) and round(256*sin) at 0, 20, ... 160 degrees
    localparam logic signed [9:0] COS_Q [`THETA_STEPS] = '{
        10'sd256, 10'sd241, 10'sd196, 10'sd128, 10'sd44,
        -10'sd44, -10'sd128, -10'sd196, -10'sd241
    };

    localparam logic signed [9:0] SIN_Q [`THETA_STEPS] = '{
        10'sd0, 10'sd88, 10'sd165, 10'sd222, 10'sd252,
        10'sd252, 10'sd222, 10'sd165, 10'sd88
    };

endpackage

// ==== hdl/hough_top.sv ====
`timescale 1ns/1ns
/*
 * Top of the Hough line finder. Pixels go in through a write port with a full
 * flag and one best line comes out per frame, marked by line_valid.
 */
module hough_top (
    input  logic                   clock,
    input  logic                   reset,
    input  logic                   pixel_wr_en,
    input  hough_pkg::pixel_word_t pixel_din,
    output logic                   pixel_full,
    output logic                   line_valid,
    output hough_pkg::rho_t        line_rho,
    output hough_pkg::theta_t      line_theta,
    output hough_pkg::vote_t       line_votes
);
    import hough_pkg::*;

    // Edge points from the window into the FIFO
    logic        push;
    edge_entry_t push_data;
    logic        fifo_full;

    // Head of the FIFO into the voter
    logic        pop;
    edge_entry_t pop_data;
    logic        fifo_empty;

    pixel_window window_inst (
        .clock       (clock),
        .reset       (reset),
        .pixel_wr_en (pixel_wr_en),
        .pixel_din   (pixel_din),
        .pixel_full  (pixel_full),
        .push        (push),
        .push_data   (push_data),
        .fifo_full   (fifo_full)
    );

    point_fifo fifo_inst (
        .clock      (clock),
        .reset      (reset),
        .push       (push),
        .push_data  (push_data),
        .fifo_full  (fifo_full),
        .pop        (pop),
        .pop_data   (pop_data),
        .fifo_empty (fifo_empty)
    );

    hough_accumulator accum_inst (
        .clock      (clock),
        .reset      (reset),
        .pop        (pop),
        .pop_data   (pop_data),
        .fifo_empty (fifo_empty),
        .line_valid (line_valid),
        .line_rho   (line_rho),
        .line_theta (line_theta),
        .line_votes (line_votes)
    );

endmodule

// ==== hdl/pixel_window.sv ====
`timescale 1ns/1ns
/*
 * Pixel front end. Tracks raster position, crops to the window, thresholds the
 * grayscale value and hands edge points plus an end-of-frame marker to the FIFO.
 */
`include "hough_config.svh"

module pixel_window (
    input  logic                   clock,
    input  logic                   reset,
    input  logic                   pixel_wr_en,
    input  hough_pkg::pixel_word_t pixel_din,
    output logic                   pixel_full,
    output logic                   push,
    output hough_pkg::edge_entry_t push_data,
    input  logic                   fifo_full
);
    import hough_pkg::*;

    localparam int X_BITS = $clog2(`IMAGE_WIDTH);
    localparam int Y_BITS = $clog2(`IMAGE_HEIGHT);

    logic [X_BITS-1:0] x_count;
    logic [Y_BITS-1:0] y_count;
    logic              accept;
    logic              last_pixel;
    logic              in_window;
    logic              is_edge;
    logic              out_valid;
    logic [9:0]        channel_sum;
    logic [7:0]        gray;
    edge_entry_t       entry;

    // Output register stalls the writer only when the FIFO refuses it
    assign pixel_full = out_valid && fifo_full;
    assign push       = out_valid && !fifo_full;
    assign accept     = pixel_wr_en && !pixel_full;

    always_comb begin
        channel_sum = 10'(pixel_din.rgb.red) + 10'(pixel_din.rgb.green)
                    + 10'(pixel_din.rgb.blue);
        gray        = 8'(channel_sum / 10'd3);
        is_edge     = (gray >= 8'(`EDGE_THRESHOLD));
        in_window   = (x_count >= X_BITS'(`WINDOW_X0)) && (x_count <= X_BITS'(`WINDOW_X1))
                   && (y_count >= Y_BITS'(`WINDOW_Y0)) && (y_count <= Y_BITS'(`WINDOW_Y1));
        last_pixel  = (x_count == X_BITS'(`IMAGE_WIDTH - 1))
                   && (y_count == Y_BITS'(`IMAGE_HEIGHT - 1));
        entry.last  = 1'b0;
        entry.x     = coord_t'(x_count - X_BITS'(`WINDOW_X0));
        entry.y     = coord_t'(y_count - Y_BITS'(`WINDOW_Y0));
    end

    // Raster counters and output register occupancy
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            x_count   <= '0;
            y_count   <= '0;
            out_valid <= 1'b0;
        end else begin
            if (accept) begin
                if (x_count == X_BITS'(`IMAGE_WIDTH - 1)) begin
                    x_count <= '0;
                    y_count <= last_pixel ? '0 : y_count + 1'b1;
                end else begin
                    x_count <= x_count + 1'b1;
                end
            end
            if (accept && (last_pixel || (in_window && is_edge))) begin
                out_valid <= 1'b1;
            end else if (push) begin
                out_valid <= 1'b0;
            end
        end
    end

    // The window ends above the bottom row, so the final pixel is never an
    // edge point and the marker can take its slot in the output register
    always_ff @(posedge clock) begin
        if (accept && last_pixel) begin
            push_data <= '{last: 1'b1, x: '0, y: '0};
        end else if (accept && in_window && is_edge) begin
            push_data <= entry;
        end
    end

endmodule

// ==== hdl/point_fifo.sv ====
`timescale 1ns/1ns
/*
 * Small synchronous FIFO between the pixel window and the Hough voter.
 * Absorbs bursts of edge points while each point is voted over all theta steps.
 */
`include "hough_config.svh"

module point_fifo (
    input  logic                   clock,
    input  logic                   reset,
    input  logic                   push,
    input  hough_pkg::edge_entry_t push_data,
    output logic                   fifo_full,
    input  logic                   pop,
    output hough_pkg::edge_entry_t pop_data,
    output logic                   fifo_empty
);
    import hough_pkg::*;

    localparam int PTR_BITS = $clog2(`FIFO_DEPTH);

    edge_entry_t       mem [`FIFO_DEPTH];
    logic [PTR_BITS:0] wr_ptr;
    logic [PTR_BITS:0] rd_ptr;
    logic [PTR_BITS:0] wr_ptr_seen;

    // Extra pointer bit tells full from empty
    assign fifo_full = (wr_ptr[PTR_BITS] != rd_ptr[PTR_BITS])
                    && (wr_ptr[PTR_BITS-1:0] == rd_ptr[PTR_BITS-1:0]);

    // Read side sees a new entry one cycle after its write
    assign fifo_empty = (rd_ptr == wr_ptr_seen);
    assign pop_data   = mem[rd_ptr[PTR_BITS-1:0]];

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            wr_ptr      <= '0;
            rd_ptr      <= '0;
            wr_ptr_seen <= '0;
        end else begin
            wr_ptr_seen <= wr_ptr;
            if (push && !fifo_full) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop && !fifo_empty) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (push && !fifo_full) begin
            mem[wr_ptr[PTR_BITS-1:0]] <= push_data;
        end
    end

endmodule

// ==== hough_lines.f ====
+incdir+include
hdl/hough_pkg.sv
hdl/pixel_window.sv
hdl/point_fifo.sv
hdl/hough_accumulator.sv
hdl/hough_top.sv
tests/hough_tb.sv

// ==== include/hough_config.svh ====
/*
 * Frame geometry, window, threshold and accumulator sizing for the Hough pipeline.
 * Include wherever one of these constants is needed.
 */
`ifndef HOUGH_CONFIG_SVH
`define HOUGH_CONFIG_SVH

// Pixels of the full frame arrive in raster order
`define IMAGE_WIDTH     40
`define IMAGE_HEIGHT    24

// Region of interest with inclusive bounds
`define WINDOW_X0       4
`define WINDOW_X1       35
`define WINDOW_Y0       4
`define WINDOW_Y1       19

`define EDGE_THRESHOLD  128
`define FIFO_DEPTH      8

// Theta step k is 20*k degrees
`define THETA_STEPS     9
`define RHO_OFFSET      40
`define RHO_RANGE       80

`endif

// ==== tests/hough_tb.sv ====
/*
 * Testbench for the Hough line finder. Streams frames into hough_top and
 * compares every reported line with a reference model of the pipeline rules.
 */
`timescale 1ns/1ns
`include "hough_config.svh"

module hough_tb;
    import hough_pkg::*;

    localparam int PIXELS     = `IMAGE_WIDTH * `IMAGE_HEIGHT;
    localparam int CELLS      = `THETA_STEPS * `RHO_RANGE;
    localparam int NUM_FRAMES = 9;

    typedef struct packed {
        rho_t   rho;
        theta_t theta;
        vote_t  votes;
    } line_result_t;

    logic         clock;
    logic         reset;
    logic         pixel_wr_en;
    pixel_word_t  pixel_din;
    logic         pixel_full;
    logic         line_valid;
    rho_t         line_rho;
    theta_t       line_theta;
    vote_t        line_votes;

    pixel_word_t  frame [PIXELS];
    pixel_word_t  frames [NUM_FRAMES][PIXELS];
    int           pause_odds [NUM_FRAMES];
    int           frame_count;
    int           frames_checked;
    int           cycle_count;
    int           cycle_limit;
    int           full_stalls;
    int           dense_first;
    line_result_t expected_q [$];

    hough_top uut (
        .clock       (clock),
        .reset       (reset),
        .pixel_wr_en (pixel_wr_en),
        .pixel_din   (pixel_din),
        .pixel_full  (pixel_full),
        .line_valid  (line_valid),
        .line_rho    (line_rho),
        .line_theta  (line_theta),
        .line_votes  (line_votes)
    );

    always #4 clock = ~clock;

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("Done: errors found");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    task automatic check_rho(input rho_t actual, input rho_t expected);
        if (actual !== expected) begin
            abort_run($sformatf("CHECK FAILED: line_rho frame %0d got 0x%h expected 0x%h",
                                frames_checked, actual, expected));
        end
    endtask

    task automatic check_theta(input theta_t actual, input theta_t expected);
        if (actual !== expected) begin
            abort_run($sformatf("CHECK FAILED: line_theta frame %0d got 0x%h expected 0x%h",
                                frames_checked, actual, expected));
        end
    endtask

    task automatic check_votes(input vote_t actual, input vote_t expected);
        if (actual !== expected) begin
            abort_run($sformatf("CHECK FAILED: line_votes frame %0d got 0x%h expected 0x%h",
                                frames_checked, actual, expected));
        end
    endtask

    task automatic check_full(input logic actual, input logic expected);
        if (actual !== expected) begin
            abort_run($sformatf("CHECK FAILED: pixel_full got 0x%h expected 0x%h",
                                actual, expected));
        end
    endtask

    function automatic bit inside_window(input int x, input int y);
        return (x >= `WINDOW_X0) && (x <= `WINDOW_X1) && (y >= `WINDOW_Y0) && (y <= `WINDOW_Y1);
    endfunction

    // Gray is the integer mean of the three channels
    function automatic bit is_edge_pixel(input pixel_word_t p);
        int sum;
        sum = int'(p.rgb.red) + int'(p.rgb.green) + int'(p.rgb.blue);
        return (sum / 3) >= `EDGE_THRESHOLD;
    endfunction

    function automatic int count_edge_points(input pixel_word_t img [PIXELS]);
        int count;
        count = 0;
        for (int y = `WINDOW_Y0; y <= `WINDOW_Y1; y++) begin
            for (int x = `WINDOW_X0; x <= `WINDOW_X1; x++) begin
                if (is_edge_pixel(img[y * `IMAGE_WIDTH + x])) begin
                    count++;
                end
            end
        end
        return count;
    endfunction

    // Expected best line of one frame as the first maximum in theta-major order
    function automatic line_result_t reference_line(input pixel_word_t img [PIXELS]);
        int           acc [`THETA_STEPS][`RHO_RANGE];
        int           xr;
        int           yr;
        int           rho;
        int           best_count;
        line_result_t best;
        for (int k = 0; k < `THETA_STEPS; k++) begin
            for (int r = 0; r < `RHO_RANGE; r++) begin
                acc[k][r] = 0;
            end
        end
        for (int y = `WINDOW_Y0; y <= `WINDOW_Y1; y++) begin
            for (int x = `WINDOW_X0; x <= `WINDOW_X1; x++) begin
                if (is_edge_pixel(img[y * `IMAGE_WIDTH + x])) begin
                    xr = x - `WINDOW_X0;
                    yr = y - `WINDOW_Y0;
                    for (int k = 0; k < `THETA_STEPS; k++) begin
                        rho = (xr * int'(COS_Q[k]) + yr * int'(SIN_Q[k])) >>> 8;
                        if (acc[k][rho + `RHO_OFFSET] < 255) begin
                            acc[k][rho + `RHO_OFFSET]++;
                        end
                    end
                end
            end
        end
        best_count = 0;
        best.rho   = rho_t'(-`RHO_OFFSET);
        best.theta = '0;
        best.votes = '0;
        for (int k = 0; k < `THETA_STEPS; k++) begin
            for (int r = 0; r < `RHO_RANGE; r++) begin
                if (acc[k][r] > best_count) begin
                    best_count = acc[k][r];
                    best.rho   = rho_t'(r - `RHO_OFFSET);
                    best.theta = theta_t'(k);
                    best.votes = vote_t'(acc[k][r]);
                end
            end
        end
        return best;
    endfunction

    task automatic blank_frame();
        for (int i = 0; i < PIXELS; i++) begin
            frame[i].raw = 24'h000000;
        end
    endtask

    // White column at window-relative x of 10 over the full window height
    task automatic draw_vertical_line();
        blank_frame();
        for (int y = `WINDOW_Y0; y <= `WINDOW_Y1; y++) begin
            frame[y * `IMAGE_WIDTH + `WINDOW_X0 + 10].raw = 24'hFFFFFF;
        end
    endtask

    task automatic light_outside_window();
        for (int y = 0; y < `IMAGE_HEIGHT; y++) begin
            for (int x = 0; x < `IMAGE_WIDTH; x++) begin
                frame[y * `IMAGE_WIDTH + x].raw = inside_window(x, y) ? 24'h000000 : 24'hFFFFFF;
            end
        end
    endtask

    // Long column of mean 127 next to a shorter column of mean 128
    task automatic make_threshold_frame();
        blank_frame();
        for (int y = `WINDOW_Y0; y <= `WINDOW_Y1; y++) begin
            frame[y * `IMAGE_WIDTH + `WINDOW_X0 + 5].raw = 24'h80807F;
        end
        for (int y = `WINDOW_Y0 + 2; y <= `WINDOW_Y0 + 9; y++) begin
            frame[y * `IMAGE_WIDTH + `WINDOW_X0 + 20].raw = 24'h81807F;
        end
    endtask

    // Mostly dark noise where roughly one pixel in sixteen is an edge
    task automatic randomize_frame();
        for (int i = 0; i < PIXELS; i++) begin
            frame[i].raw = 24'($urandom);
            if ($urandom_range(7) != 0) begin
                frame[i].raw = frame[i].raw & 24'h7F7F7F;
            end
        end
    endtask

    task automatic fill_dense_window(input bit all_white);
        for (int y = 0; y < `IMAGE_HEIGHT; y++) begin
            for (int x = 0; x < `IMAGE_WIDTH; x++) begin
                frame[y * `IMAGE_WIDTH + x].raw = 24'($urandom);
                if (inside_window(x, y) && (all_white || $urandom_range(3) != 0)) begin
                    frame[y * `IMAGE_WIDTH + x].rgb.red   = 8'($urandom_range(255, 170));
                    frame[y * `IMAGE_WIDTH + x].rgb.green = 8'($urandom_range(255, 170));
                    frame[y * `IMAGE_WIDTH + x].rgb.blue  = 8'($urandom_range(255, 170));
                end
            end
        end
    endtask

    task automatic store_frame(input int odds);
        for (int i = 0; i < PIXELS; i++) begin
            frames[frame_count][i] = frame[i];
        end
        pause_odds[frame_count] = odds;
        expected_q.push_back(reference_line(frame));
        cycle_limit += (PIXELS + count_edge_points(frame) * `THETA_STEPS + CELLS + 50) * 2;
        frame_count++;
    endtask

    // Odds of zero means the writer never pauses on its own
    task automatic send_pixel(input pixel_word_t value, input int odds);
        bit sent;
        bit pause;
        sent = 1'b0;
        while (!sent) begin
            @(negedge clock);
            pause = 1'b0;
            if (odds != 0) begin
                pause = ($urandom_range(odds - 1) == 0);
            end
            if (pixel_full || pause) begin
                if (pixel_full) begin
                    full_stalls++;
                end
                pixel_wr_en = 1'b0;
            end else begin
                pixel_wr_en = 1'b1;
                pixel_din   = value;
                sent        = 1'b1;
            end
        end
    endtask

    task automatic send_frame(input int index);
        for (int i = 0; i < PIXELS; i++) begin
            send_pixel(frames[index][i], pause_odds[index]);
        end
    endtask

    initial begin
        clock          = 1'b0;
        reset          = 1'b1;
        pixel_wr_en    = 1'b0;
        pixel_din      = '0;
        frame_count    = 0;
        frames_checked = 0;
        cycle_count    = 0;
        cycle_limit    = 0;
        full_stalls    = 0;
        dense_first    = 0;
        void'($urandom(29430));
        draw_vertical_line();
        store_frame(0);
        light_outside_window();
        store_frame(0);
        make_threshold_frame();
        store_frame(0);
        repeat (4) begin
            randomize_frame();
            store_frame(4);
        end
        dense_first = frame_count;
        fill_dense_window(1'b1);
        store_frame(0);
        fill_dense_window(1'b0);
        store_frame(0);
        repeat (2) @(posedge clock);
        @(negedge clock);
        reset = 1'b0;
        check_full(pixel_full, 1'b0);
        for (int f = 0; f < frame_count; f++) begin
            // Stalls are counted over the dense frames only
            if (f == dense_first) begin
                full_stalls = 0;
            end
            send_frame(f);
        end
        @(negedge clock);
        pixel_wr_en = 1'b0;
        while (expected_q.size() != 0) begin
            @(negedge clock);
        end
        repeat (20) @(negedge clock);
        if (full_stalls == 0) begin
            abort_run("pixel_full never rose while the dense frames were sent");
        end else if (expected_q.size() == 0 && frames_checked == frame_count) begin
            $display("Done: no errors");
            $finish;
        end else begin
            abort_run("Some frames never produced a line result");
        end
    end

    // One expected result is consumed on each line_valid pulse
    always @(negedge clock) begin
        line_result_t expected;
        if (!reset && line_valid) begin
            if (expected_q.size() == 0) begin
                abort_run("line_valid pulsed with no frame outstanding");
            end else begin
                expected = expected_q.pop_front();
                check_rho(line_rho, expected.rho);
                check_theta(line_theta, expected.theta);
                check_votes(line_votes, expected.votes);
                frames_checked++;
            end
        end
    end

    always @(posedge clock) begin
        cycle_count++;
        if (cycle_count > cycle_limit) begin
            abort_run($sformatf("Timed out after %0d cycles with %0d of %0d frames reported",
                                cycle_count, frames_checked, frame_count));
        end
    end

endmodule
